// File: common/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // ========================================
    // Cache geometry
    // ========================================
    localparam int XLEN      = 32;   // Processor word width
    localparam int LINE_BITS = 128;  // One line moved per memory transfer
    localparam int N_WAYS    = 4;
    localparam int N_SETS    = 16;

    // ========================================
    // Address fields, LSB first
    // ========================================
    // Byte offset inside a word
    localparam int BYTE_SEL_BITS = $clog2(XLEN / 8);
    localparam int WORD_SEL_BITS = $clog2(LINE_BITS / XLEN);  // Word inside a line
    localparam int SET_BITS      = $clog2(N_SETS);            // Set index
    // Whatever is left of the address is the tag
    localparam int TAG_BITS      = XLEN - SET_BITS - WORD_SEL_BITS - BYTE_SEL_BITS;

    localparam int WAY_BITS = $clog2(N_WAYS);  // Way number width

endpackage

// File: common/cache_types_pkg.sv
package cache_types_pkg;

    import cache_cfg_pkg::*;

    // ========================================
    // Payload types
    // ========================================
    typedef logic [XLEN-1:0]      word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    // Per-way bookkeeping, one entry per set
    typedef struct packed {
        logic valid;
        logic dirty;   // Line differs from memory
        tag_t tag;
    } way_meta_t;

    // Processor request, sampled with the strobe
    typedef struct packed {
        logic              write;    // 1 for store
        logic [XLEN/8-1:0] byte_en;  // Bytes written on a store
        logic [XLEN-1:0]   addr;
        word_t             wdata;
    } cpu_req_t;

    // Line request toward memory
    typedef struct packed {
        logic            write;  // 1 for write-back
        logic [XLEN-1:0] addr;   // Always line aligned
        line_t           data;   // Victim line on write-back
    } mem_req_t;

    // ========================================
    // Controller states
    // ========================================
    typedef enum logic [2:0] {
        INIT,
        IDLE,
        LOOKUP,
        WRITE_BACK,
        WB_DONE,
        FILL,
        FILL_DONE
    } cache_state_t;

endpackage

// File: dcache/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  logic                                              p_strobe_i,
    input  cache_types_pkg::cpu_req_t                         p_req_i,
    output cache_types_pkg::word_t                            p_rdata_o,
    output logic                                              p_ready_o,
    output logic                                              m_strobe_o,
    output cache_types_pkg::mem_req_t                         m_req_o,
    input  logic                                              m_ready_i,
    input  cache_types_pkg::line_t                            m_rdata_i,
    output logic [cache_cfg_pkg::SET_BITS-1:0]                index_o,
    output cache_types_pkg::tag_t                             tag_o,
    output logic [cache_cfg_pkg::N_WAYS-1:0]                  we_o,
    output cache_types_pkg::line_t                            wline_o,
    output cache_types_pkg::way_meta_t                        wmeta_o,
    input  logic                                              hit_i,
    input  logic [cache_cfg_pkg::WAY_BITS-1:0]                hit_way_i,
    input  cache_types_pkg::line_t                            hit_line_i,
    input  cache_types_pkg::way_meta_t [cache_cfg_pkg::N_WAYS-1:0] meta_i,
    input  cache_types_pkg::line_t     [cache_cfg_pkg::N_WAYS-1:0] line_i,
    input  logic [cache_cfg_pkg::WAY_BITS-1:0]                victim_i,
    output logic                                              advance_o,
    output cache_types_pkg::line_t                            base_line_o,
    input  cache_types_pkg::word_t                            word_i,
    input  cache_types_pkg::line_t                            merged_i,
    output cache_types_pkg::cpu_req_t                         req_o
);

    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    cache_state_t        state_q, state_d;
    logic [SET_BITS-1:0] init_cnt_q;   // Set being cleared in INIT
    cpu_req_t            req_q;        // Request in flight
    line_t               fill_q;       // Line returned by memory
    logic                start_wb;     // Entering WRITE_BACK
    logic                start_fill;   // Entering FILL
    logic                mem_wr_q;
    logic [XLEN-1:0]     mem_addr_q;
    line_t               mem_data_q;
    way_meta_t           vmeta;        // Metadata of the victim way
    logic                accept;
    logic                write_hit;
    logic                fill_done;

    assign accept    = (state_q == IDLE) && p_strobe_i;  // Strobes elsewhere are dropped
    assign vmeta     = meta_i[victim_i];
    assign write_hit = (state_q == LOOKUP) && hit_i && req_q.write;
    assign fill_done = (state_q == FILL_DONE);

    // ========================================
    // State machine
    // ========================================
    always_comb
    begin
        state_d    = state_q;
        start_wb   = 1'b0;
        start_fill = 1'b0;
        case (state_q)
            INIT:
                if (init_cnt_q == SET_BITS'(N_SETS - 1))
                    state_d = IDLE;         // Last set cleared
            IDLE:
                if (p_strobe_i)
                    state_d = LOOKUP;
            LOOKUP:
                if (hit_i)
                    state_d = IDLE;         // Hit served this cycle
                else if (vmeta.valid && vmeta.dirty)
                begin
                    state_d  = WRITE_BACK;  // Victim must go out first
                    start_wb = 1'b1;
                end
                else
                begin
                    state_d    = FILL;
                    start_fill = 1'b1;
                end
            WRITE_BACK:
                if (m_ready_i)
                    state_d = WB_DONE;
            WB_DONE:
            begin
                state_d    = FILL;
                start_fill = 1'b1;
            end
            FILL:
                if (m_ready_i)
                    state_d = FILL_DONE;
            FILL_DONE:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q    <= INIT;
            init_cnt_q <= '0;
            m_strobe_o <= 1'b0;
            mem_wr_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == INIT)
                init_cnt_q <= init_cnt_q + 1'b1;
            m_strobe_o <= start_wb | start_fill;  // Single pulse on entry
            if (start_wb | start_fill)
                mem_wr_q <= start_wb;
        end
    end

    // ========================================
    // Request and memory payload
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (accept)
            req_q <= p_req_i;
        if ((state_q == FILL) && m_ready_i)
            fill_q <= m_rdata_i;    // Line valid only with ready
        if (start_wb)
        begin
            // Victim address rebuilt from its tag and the current set
            mem_addr_q <= {vmeta.tag, index_o, {(WORD_SEL_BITS + BYTE_SEL_BITS){1'b0}}};
            mem_data_q <= line_i[victim_i];
        end
        else if (start_fill)
        begin
            mem_addr_q <= {req_q.addr[XLEN-1:WORD_SEL_BITS + BYTE_SEL_BITS],
                           {(WORD_SEL_BITS + BYTE_SEL_BITS){1'b0}}};
            mem_data_q <= '0;
        end
    end

    assign m_req_o = '{write: mem_wr_q, addr: mem_addr_q, data: mem_data_q};
    assign req_o   = req_q;

    // ========================================
    // RAM side
    // ========================================
    always_comb
    begin
        if (state_q == INIT)
            index_o = init_cnt_q;
        else if (accept)
            index_o = p_req_i.addr[BYTE_SEL_BITS + WORD_SEL_BITS +: SET_BITS];  // Early read
        else
            index_o = req_q.addr[BYTE_SEL_BITS + WORD_SEL_BITS +: SET_BITS];
    end

    assign tag_o       = req_q.addr[XLEN-1 -: TAG_BITS];
    assign base_line_o = fill_done ? fill_q : hit_line_i;  // Merge on hit line or fill
    assign wline_o     = req_q.write ? merged_i : fill_q;  // Reads keep the raw fill
    assign advance_o   = fill_done;

    always_comb
    begin
        we_o    = '0;
        wmeta_o = '0;                               // INIT writes invalid entries
        if (state_q == INIT)
            we_o = '1;
        else if (write_hit)
        begin
            we_o[hit_way_i] = 1'b1;
            wmeta_o         = '{valid: 1'b1, dirty: 1'b1, tag: tag_o};
        end
        else if (fill_done)
        begin
            we_o[victim_i] = 1'b1;
            wmeta_o        = '{valid: 1'b1, dirty: req_q.write, tag: tag_o};
        end
    end

    // ========================================
    // Processor side
    // ========================================
    assign p_ready_o = ((state_q == LOOKUP) && hit_i) || fill_done;
    assign p_rdata_o = (p_ready_o && !req_q.write) ? word_i : '0;

endmodule

// File: dcache/dcache_top.sv
module dcache_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    // Processor port
    input  logic                       p_strobe_i,
    input  cache_types_pkg::cpu_req_t  p_req_i,
    output cache_types_pkg::word_t     p_rdata_o,
    output logic                       p_ready_o,
    // Memory port
    output logic                       m_strobe_o,
    output cache_types_pkg::mem_req_t  m_req_o,
    input  logic                       m_ready_i,
    input  cache_types_pkg::line_t     m_rdata_i
);

    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    // ========================================
    // Internal nets
    // ========================================
    logic [SET_BITS-1:0]          index;      // RAM set index
    tag_t                         tag;        // Tag of the request in flight
    logic [N_WAYS-1:0]            we;         // Per-way write enables
    line_t                        wline;
    way_meta_t                    wmeta;
    logic                         hit;
    logic [WAY_BITS-1:0]          hit_way;
    line_t                        hit_line;
    way_meta_t [N_WAYS-1:0]       meta;       // Every way, for victim choice
    line_t     [N_WAYS-1:0]       lines;
    logic [WAY_BITS-1:0]          victim;
    logic                         advance;    // FIFO step after a fill
    line_t                        base_line;  // Line fed to the merge unit
    word_t                        word;
    line_t                        merged;
    cpu_req_t                     req_r;      // Registered processor request

    dcache_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .p_strobe_i  (p_strobe_i),
        .p_req_i     (p_req_i),
        .p_rdata_o   (p_rdata_o),
        .p_ready_o   (p_ready_o),
        .m_strobe_o  (m_strobe_o),
        .m_req_o     (m_req_o),
        .m_ready_i   (m_ready_i),
        .m_rdata_i   (m_rdata_i),
        .index_o     (index),
        .tag_o       (tag),
        .we_o        (we),
        .wline_o     (wline),
        .wmeta_o     (wmeta),
        .hit_i       (hit),
        .hit_way_i   (hit_way),
        .hit_line_i  (hit_line),
        .meta_i      (meta),
        .line_i      (lines),
        .victim_i    (victim),
        .advance_o   (advance),
        .base_line_o (base_line),
        .word_i      (word),
        .merged_i    (merged),
        .req_o       (req_r)
    );

    dcache_ways u_ways (
        .clk_i      (clk_i),
        .index_i    (index),
        .tag_i      (tag),
        .we_i       (we),
        .wline_i    (wline),
        .wmeta_i    (wmeta),
        .hit_o      (hit),
        .hit_way_o  (hit_way),
        .hit_line_o (hit_line),
        .meta_o     (meta),
        .line_o     (lines)
    );

    fifo_victim u_victim (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .index_i   (index),
        .advance_i (advance),
        .victim_o  (victim)
    );

    // Word offset, byte enables and store data come from the held request
    line_merge u_merge (
        .line_i     (base_line),
        .word_sel_i (req_r.addr[BYTE_SEL_BITS +: WORD_SEL_BITS]),
        .byte_en_i  (req_r.byte_en),
        .wdata_i    (req_r.wdata),
        .word_o     (word),
        .line_o     (merged)
    );

endmodule

// File: dcache/dcache_ways.sv
module dcache_ways (
    input  logic                                              clk_i,
    input  logic [cache_cfg_pkg::SET_BITS-1:0]                index_i,
    input  cache_types_pkg::tag_t                             tag_i,
    input  logic [cache_cfg_pkg::N_WAYS-1:0]                  we_i,
    input  cache_types_pkg::line_t                            wline_i,
    input  cache_types_pkg::way_meta_t                        wmeta_i,
    output logic                                              hit_o,
    output logic [cache_cfg_pkg::WAY_BITS-1:0]                hit_way_o,
    output cache_types_pkg::line_t                            hit_line_o,
    output cache_types_pkg::way_meta_t [cache_cfg_pkg::N_WAYS-1:0] meta_o,
    output cache_types_pkg::line_t     [cache_cfg_pkg::N_WAYS-1:0] line_o
);

    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    logic [N_WAYS-1:0] way_hit;   // One-hot when all is well

    // ========================================
    // Storage, one line RAM and one tag RAM per way
    // ========================================
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        sync_ram #(
            .entry_t (line_t),
            .DEPTH   (N_SETS)
        ) u_line_ram (
            .clk_i   (clk_i),
            .we_i    (we_i[w]),
            .addr_i  (index_i),
            .wdata_i (wline_i),
            .rdata_o (line_o[w])
        );

        sync_ram #(
            .entry_t (way_meta_t),
            .DEPTH   (N_SETS)
        ) u_meta_ram (
            .clk_i   (clk_i),
            .we_i    (we_i[w]),
            .addr_i  (index_i),
            .wdata_i (wmeta_i),
            .rdata_o (meta_o[w])
        );

        // Tag is already held by the controller, RAM output is one cycle late
        assign way_hit[w] = meta_o[w].valid && (meta_o[w].tag == tag_i);
    end

    // ========================================
    // Hit decode
    // ========================================
    always_comb
    begin
        case (way_hit)
            4'b0001: hit_way_o = 2'd0;
            4'b0010: hit_way_o = 2'd1;
            4'b0100: hit_way_o = 2'd2;
            4'b1000: hit_way_o = 2'd3;
            default: hit_way_o = 2'd0;   // No hit, or several ways matched
        endcase
    end

    assign hit_o      = |way_hit;
    assign hit_line_o = line_o[hit_way_o];

endmodule

// File: dcache/fifo_victim.sv
module fifo_victim (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [cache_cfg_pkg::SET_BITS-1:0] index_i,
    input  logic                               advance_i,
    output logic [cache_cfg_pkg::WAY_BITS-1:0] victim_o
);

    import cache_cfg_pkg::*;

    logic [WAY_BITS-1:0] cnt_q [N_SETS];  // Oldest way of each set

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                cnt_q[s] <= '0;
            victim_o <= '0;
        end
        else
        begin
            victim_o <= cnt_q[index_i];        // Lines up with the RAM read
            if (advance_i)
                cnt_q[index_i] <= cnt_q[index_i] + 1'b1;  // Wraps round-robin
        end
    end

endmodule

// File: dcache/line_merge.sv
module line_merge (
    input  cache_types_pkg::line_t                  line_i,
    input  logic [cache_cfg_pkg::WORD_SEL_BITS-1:0] word_sel_i,
    input  logic [cache_cfg_pkg::XLEN/8-1:0]        byte_en_i,
    input  cache_types_pkg::word_t                  wdata_i,
    output cache_types_pkg::word_t                  word_o,
    output cache_types_pkg::line_t                  line_o
);

    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    word_t old_word;   // Selected word as stored
    word_t new_word;   // Same word after the store

    // Word 0 sits in the low bits of the line
    assign old_word = line_i[word_sel_i * XLEN +: XLEN];
    assign word_o   = old_word;

    // Byte lanes
    always_comb
    begin
        new_word = old_word;
        for (int b = 0; b < XLEN / 8; b++)
        begin
            if (byte_en_i[b])
                new_word[b * 8 +: 8] = wdata_i[b * 8 +: 8];
        end
    end

    // Put the word back, rest of the line untouched
    always_comb
    begin
        line_o = line_i;
        line_o[word_sel_i * XLEN +: XLEN] = new_word;
    end

endmodule

// File: hw/sync_ram.sv
module sync_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem_q [DEPTH];  // Storage array

    // Registered read port, write data shows up on the output first
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem_q[addr_i] <= wdata_i;
            rdata_o       <= wdata_i;   // Write-first
        end
        else
        begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then search the log for the pass line
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f verilog.f -o tb_dcache > build.log 2>&1 \
    && ./obj_dir/tb_dcache > sim.log 2>&1 \
    || { echo "Build or simulation stopped with an error"; tail -n 20 build.log; }

[ -f sim.log ] && cat sim.log
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

// File: testbench/dcache_chk.sv
module dcache_chk (
    input logic clk_i,
    input logic rst_i,
    input logic p_ready_i,
    input logic m_strobe_i
);

    import cache_cfg_pkg::*;

    logic [7:0] run_cnt_q;   // Cycles since reset release, saturates

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            run_cnt_q <= '0;
        else if (run_cnt_q != '1)
            run_cnt_q <= run_cnt_q + 1'b1;
    end

    // ========================================
    // Controller output rules
    // ========================================
    ready_apart_from_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        !(p_ready_i && m_strobe_i))
        else $error("p_ready_o and m_strobe_o high in the same cycle");

    // Memory request is a single-cycle pulse
    strobe_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |=> !m_strobe_i)
        else $error("m_strobe_o high for two cycles in a row");

    no_ready_during_init: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |-> (run_cnt_q >= 8'(N_SETS)))   // INIT clears one set per cycle
        else $error("p_ready_o before the metadata was cleared");

endmodule

bind dcache_ctrl dcache_chk u_chk (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .p_ready_i  (p_ready_o),
    .m_strobe_i (m_strobe_o)
);

// File: testbench/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;   // Free running
    end

    // Synchronous reset, released just after an edge
    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: testbench/tb_dcache.sv
module tb_dcache;

    import cache_cfg_pkg::*;
    import cache_types_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DLY    = 2;                   // Input skew after the rising edge
    localparam int N_WORDS      = LINE_BITS / XLEN;
    localparam int N_RAND       = 40;                  // Requests in the random mix
    localparam int N_REQS       = 36 + N_RAND;         // All tests together
    localparam int MISS_CYCLES  = 18;                  // Dirty miss with the slowest memory
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + N_SETS + N_REQS * MISS_CYCLES) * CLK_PERIOD;

    logic     clk;
    logic     rst;
    logic     p_strobe;
    cpu_req_t p_req;
    word_t    p_rdata;
    logic     p_ready;
    logic     m_strobe;
    mem_req_t m_req;
    logic     m_ready;
    line_t    m_rdata;

    logic [15:0]     lfsr_q = 16'd94;
    line_t           mem_lines [logic [XLEN-1:0]];  // Written-back lines keyed by line address
    logic [7:0]      ref_bytes [logic [XLEN-1:0]];  // Bytes stored by the processor
    logic [XLEN-1:0] wb_addr_q [$];                 // Write-back log
    line_t           wb_data_q [$];
    int              rd_cnt    = 0;
    int              wr_cnt    = 0;
    int              checks    = 0;
    int              errors    = 0;
    int              test_errs = 0;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    dcache_top dut0 (
        .clk_i      (clk),
        .rst_i      (rst),
        .p_strobe_i (p_strobe),
        .p_req_i    (p_req),
        .p_rdata_o  (p_rdata),
        .p_ready_o  (p_ready),
        .m_strobe_o (m_strobe),
        .m_req_o    (m_req),
        .m_ready_i  (m_ready),
        .m_rdata_i  (m_rdata)
    );

    // ========================================
    // Stimulus and reference helpers
    // ========================================
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic word_t preload_word(input logic [XLEN-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'h5A3C_96E1;   // Rotated address gives unique words
    endfunction

    function automatic logic [XLEN-1:0] mk_addr(input tag_t tag,
                                                input logic [SET_BITS-1:0] set_idx,
                                                input logic [WORD_SEL_BITS-1:0] word);
        return {tag, set_idx, word, {BYTE_SEL_BITS{1'b0}}};
    endfunction

    // Memory holds the written-back line or else the preload
    function automatic line_t mem_line(input logic [XLEN-1:0] la);
        line_t l;
        if (mem_lines.exists(la))
            return mem_lines[la];
        for (int w = 0; w < N_WORDS; w++)
            l[w*XLEN +: XLEN] = preload_word(la + 32'(w * 4));
        return l;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [XLEN-1:0] a);
        word_t w;
        if (ref_bytes.exists(a))
            return ref_bytes[a];
        w = preload_word({a[XLEN-1:2], 2'b00});
        return w[int'(a[1:0]) * 8 +: 8];
    endfunction

    function automatic word_t ref_word(input logic [XLEN-1:0] a);
        word_t w;
        for (int b = 0; b < 4; b++)
            w[b*8 +: 8] = ref_byte({a[XLEN-1:2], 2'b00} + 32'(b));
        return w;
    endfunction

    function automatic line_t ref_line(input logic [XLEN-1:0] la);
        line_t l;
        for (int w = 0; w < N_WORDS; w++)
            l[w*XLEN +: XLEN] = ref_word(la + 32'(w * 4));
        return l;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        assert (cond)
        else
        begin
            $display("ERROR t=%0t %s", $time, msg);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s, %0d errors", name, (test_errs == 0) ? "pass" : "fail", test_errs);
        errors    += test_errs;
        test_errs  = 0;
    endtask

    // One processor request with its read data checked against the reference
    task automatic access(input logic wr, input logic [3:0] be, input logic [XLEN-1:0] addr,
                          input word_t wdata, output int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b1;
        p_req    = '{write: wr, byte_en: be, addr: addr, wdata: wdata};
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b0;
        cycles   = 1;
        @(negedge clk);                 // Outputs settled mid-cycle
        while (!p_ready)
        begin
            cycles++;
            @(negedge clk);
        end
        if (wr)
        begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    ref_bytes[{addr[XLEN-1:2], 2'b00} + 32'(b)] = wdata[b*8 +: 8];
        end
        else
            check_word("p_rdata_o", p_rdata, ref_word(addr));
    endtask

    // ========================================
    // Memory model
    // ========================================
    always
    begin : mem_model
        mem_req_t req;
        int       delay;
        @(negedge clk);
        if (m_strobe)
        begin
            req = m_req;                // Held by the DUT until ready
            if (req.write)
            begin
                wr_cnt++;
                wb_addr_q.push_back(req.addr);
                wb_data_q.push_back(req.data);
                mem_lines[req.addr] = req.data;
            end
            else
                rd_cnt++;
            delay = 1 + int'(rand_bits(2));   // 1 to 4 cycles
            repeat (delay) @(posedge clk);
            #DRIVE_DLY;
            m_ready = 1'b1;
            m_rdata = req.write ? '0 : mem_line(req.addr);
            @(posedge clk);
            #DRIVE_DLY;
            m_ready = 1'b0;
            m_rdata = '0;
        end
    end

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_read_miss_hit();
        logic [XLEN-1:0] base;
        int              cycles;
        int              rd0;
        int              wr0;
        base = mk_addr(24'h000010, 4'd3, 2'd0);
        rd0  = rd_cnt;
        wr0  = wr_cnt;
        access(1'b0, 4'h0, base + 32'd4, '0, cycles);
        check_true(rd_cnt == rd0 + 1 && wr_cnt == wr0, "read miss did not do one line read");
        for (int w = 0; w < N_WORDS; w++)
        begin
            rd0 = rd_cnt;
            access(1'b0, 4'h0, base + 32'(w * 4), '0, cycles);
            check_true(cycles == 1, $sformatf("read hit took %0d cycles", cycles));
            check_true(rd_cnt == rd0 && wr_cnt == wr0, "read hit went to memory");
        end
        finish_test("read miss then hit");
    endtask

    task automatic test_byte_writes();
        logic [3:0]      be_list [5];
        logic [XLEN-1:0] addr;
        int              cycles;
        int              rd0;
        int              wr0;
        be_list = '{4'b0001, 4'b0011, 4'b0100, 4'b1100, 4'b1111};
        for (int i = 0; i < 5; i++)
        begin
            addr = mk_addr(24'h000010, 4'd3, 2'(i));  // Line left by the first test
            rd0  = rd_cnt;
            wr0  = wr_cnt;
            access(1'b1, be_list[i], addr, rand_bits(32), cycles);
            check_true(cycles == 1 && rd_cnt == rd0 && wr_cnt == wr0,
                       "write hit was slow or went to memory");
            access(1'b0, 4'h0, addr, '0, cycles);
            addr = mk_addr(24'h000020 + 24'(i), 4'(6 + i), 2'(i));   // Write miss into a new set
            rd0  = rd_cnt;
            access(1'b1, be_list[i], addr, rand_bits(32), cycles);
            check_true(rd_cnt == rd0 + 1 && wr_cnt == wr0,
                       "write miss did not do exactly one read and no write");
            access(1'b0, 4'h0, addr, '0, cycles);
        end
        finish_test("byte enabled writes");
    endtask

    task automatic test_dirty_evict();
        logic [XLEN-1:0] first;
        int              cycles;
        int              rd0;
        int              wr0;
        first = mk_addr(24'h000100, 4'd12, 2'd0);
        for (int i = 0; i < N_WAYS; i++)
            access(1'b1, 4'hF, mk_addr(24'h000100 + 24'(i), 4'd12, 2'd0), rand_bits(32), cycles);
        wr0 = wr_cnt;
        access(1'b1, 4'hF, mk_addr(24'h000100 + 24'(N_WAYS), 4'd12, 2'd0), rand_bits(32),
               cycles);
        check_true(wr_cnt == wr0 + 1, "fifth write in the set did not write back one line");
        if (wb_addr_q.size() > 0)
        begin
            check_word("m_req_o.addr", wb_addr_q[$], first);
            check_line("m_req_o.data", wb_data_q[$], ref_line(first));
        end
        rd0 = rd_cnt;
        access(1'b0, 4'h0, first, '0, cycles);
        check_true(rd_cnt == rd0 + 1, "evicted line was still read as a hit");
        finish_test("fifo eviction with write-back");
    endtask

    task automatic test_clean_evict();
        int cycles;
        int rd0;
        int wr0;
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        for (int i = 0; i <= N_WAYS; i++)
            access(1'b0, 4'h0, mk_addr(24'h000200 + 24'(i), 4'd13, 2'(i)), '0, cycles);
        check_true(rd_cnt == rd0 + N_WAYS + 1, "clean reads did not each fetch a line");
        check_true(wr_cnt == wr0, "clean eviction wrote a line back");
        finish_test("clean eviction");
    endtask

    task automatic test_random_mix();
        logic            wr;
        logic [XLEN-1:0] addr;
        int              cycles;
        for (int n = 0; n < N_RAND; n++)
        begin
            wr   = 1'(rand_bits(1));
            addr = mk_addr(24'h000300 + 24'(rand_bits(3)), 4'(rand_bits(2)), 2'(rand_bits(2)));
            access(wr, 4'(rand_bits(4)), addr, rand_bits(32), cycles);
        end
        finish_test("random mix");
    endtask

    // ========================================
    // Run control
    // ========================================
    initial
    begin : main
        p_strobe = 1'b0;
        p_req    = '0;
        m_ready  = 1'b0;
        m_rdata  = '0;
        @(negedge rst);
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b1;                      // Dropped while the sets are cleared
        p_req    = '{write: 1'b0, byte_en: 4'h0, addr: mk_addr(24'h000010, 4'd3, 2'd1),
                     wdata: '0};
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b0;
        repeat (N_SETS) @(posedge clk);       // INIT clears one set per cycle
        test_read_miss_hit();
        test_byte_writes();
        test_dirty_evict();
        test_clean_evict();
        test_random_mix();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_TIME);
        $display("ERROR t=%0t timeout, a request never completed", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog.f
common/cache_cfg_pkg.sv
common/cache_types_pkg.sv
hw/sync_ram.sv
dcache/line_merge.sv
dcache/fifo_victim.sv
dcache/dcache_ways.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
testbench/tb_clk_gen.sv
testbench/dcache_chk.sv
testbench/tb_dcache.sv
